//--- common/cart_pkg.sv
// Shared types and sizes; VRAM is fixed at 16 KB and only eight control registers exist
`default_nettype none

package cart_pkg;

	// --------------------
	// Sizes and constants
	// --------------------
	localparam int VRAM_AW         = 14;	// 16 K bytes
	localparam int NUM_REGS        = 8;
	localparam int REG_AW          = $clog2(NUM_REGS);
	localparam int LED_REG         = 7;		// Register driving the LEDs
	localparam int DEBOUNCE_CYCLES = 64;	// Stable samples per accepted key edge
	localparam int DEB_CW          = $clog2(DEBOUNCE_CYCLES);

	localparam logic [7:0] DBG_REG7_CMD = 8'h87;	// Second port 1 byte, write R#7
	localparam logic [7:0] NOPORT_RDATA = 8'hFF;	// Unimplemented port readback

	// --------------------
	// Enums
	// --------------------
	// Port select, same encoding as the CPU address bits A1:A0
	typedef enum logic [1:0] {
		PORT_DATA = 2'd0,	// VRAM data
		PORT_CTRL = 2'd1,	// Register / address setup, status
		PORT_PAL  = 2'd2,	// Palette, not implemented
		PORT_IND  = 2'd3	// Indirect register, not implemented
	} vdp_port_e;

	// vdp_port sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_VRAM,	// Waiting for vram_done
		ST_ACK		// Port 1/2/3 action, then ack
	} port_state_e;

	// --------------------
	// Bus payloads
	// --------------------
	// One CPU-side access, 11 bits
	typedef struct packed {
		logic       wr;
		vdp_port_e  port;
		logic [7:0] wdata;
	} vdp_req_t;

	// One VRAM access, 23 bits
	typedef struct packed {
		logic               we;
		logic [VRAM_AW-1:0] addr;
		logic [7:0]         wdata;
	} vram_req_t;

endpackage

`default_nettype wire

//--- hw/vdp/vdp_port.sv
// One access in flight at a time, host wins ties; no palette, no interrupts, ports 2/3 read FFh
`default_nettype none

module vdp_port
	import cart_pkg::*;
(
	input  logic       clk,
	input  logic       w_n_reset,
	// Host requester
	input  logic       host_req,
	input  vdp_req_t   host_cmd,
	output logic       host_ack,
	// Debugger requester
	input  logic       dbg_req,
	input  vdp_req_t   dbg_cmd,
	output logic       dbg_ack,
	output logic [7:0] rdata,		// Valid in the ack cycle
	// VRAM side
	output logic       vram_req,
	output vram_req_t  vram_cmd,
	input  logic       vram_done,
	input  logic [7:0] vram_rdata,
	output logic [1:0] led
);

	port_state_e        state;
	logic               ack_q;		// One-cycle ack, steered by own_dbg
	logic               own_dbg;		// Debugger owns the current access
	vdp_req_t           cur;		// Captured access
	vdp_req_t           next_cmd;
	logic               take_host;
	logic               take_dbg;
	logic               latch;		// First port 1 byte is held
	logic [7:0]         latch_byte;
	logic [VRAM_AW-1:0] ptr;		// VRAM address pointer
	logic [7:0]         regs [NUM_REGS];
	logic [1:0]         led_q;

	// --------------------
	// Arbitration
	// --------------------
	// No new grant during the ack cycle, the requester still holds req there
	assign take_host = (state == ST_IDLE) && !ack_q && host_req;
	assign take_dbg  = (state == ST_IDLE) && !ack_q && dbg_req && !host_req;
	assign next_cmd  = take_host ? host_cmd : dbg_cmd;

	assign host_ack = ack_q && !own_dbg;
	assign dbg_ack  = ack_q && own_dbg;

	// VRAM request held for the whole ST_VRAM stay
	assign vram_req = (state == ST_VRAM);
	assign vram_cmd = '{we: cur.wr, addr: ptr, wdata: cur.wdata};

	assign led = led_q;

	// --------------------
	// Sequencer and register file
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state   <= ST_IDLE;
			ack_q   <= 1'b0;
			own_dbg <= 1'b0;
			latch   <= 1'b0;
			ptr     <= '0;
			led_q   <= '0;
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			ack_q <= 1'b0;
			led_q <= regs[LED_REG][1:0];	// LED lags the register by one cycle
			case (state)
				ST_IDLE: begin
					if (take_host || take_dbg) begin
						own_dbg <= !take_host;
						state   <= (next_cmd.port == PORT_DATA) ? ST_VRAM : ST_ACK;
					end
				end
				ST_VRAM: begin
					if (vram_done) begin
						ptr   <= ptr + 1'b1;	// Wraps at 16 K
						latch <= 1'b0;		// Data port access breaks a pair
						ack_q <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_ACK: begin
					if (cur.port == PORT_CTRL) begin
						if (!cur.wr) begin
							latch <= 1'b0;		// Status read resets the pair
						end else if (!latch) begin
							latch <= 1'b1;		// First byte
						end else begin
							latch <= 1'b0;
							// Bit 7 picks register write over address setup
							if (cur.wdata[7])
								regs[cur.wdata[REG_AW-1:0]] <= latch_byte;
							else
								ptr <= {cur.wdata[5:0], latch_byte};
						end
					end
					ack_q <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// --------------------
	// Payload capture
	// --------------------
	always_ff @(posedge clk) begin
		if (take_host || take_dbg)
			cur <= next_cmd;
		if (state == ST_ACK) begin
			if (cur.port == PORT_CTRL && cur.wr && !latch)
				latch_byte <= cur.wdata;
			// Status is the latch flag in bit 7, taken before the clear
			rdata <= (cur.port == PORT_CTRL) ? {latch, 7'd0} : NOPORT_RDATA;
		end
		if (state == ST_VRAM && vram_done && !cur.wr)
			rdata <= vram_rdata;
	end

endmodule

`default_nettype wire

//--- hw/vdp/vram_ctrl.sv
// Requests must be held until vram_done; the clear pass after reset takes 64 K cycles
`default_nettype none

module vram_ctrl
	import cart_pkg::*;
(
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic       vram_req,
	input  vram_req_t  vram_cmd,
	output logic       vram_done,
	output logic [7:0] vram_rdata,
	output logic       busy			// High during the clear pass
);

	logic [1:0]         enable_state;	// Free-running slot counter
	logic [VRAM_AW-1:0] clr_addr;
	logic               rd_done;
	logic               slot;
	logic               accept;
	logic [7:0]         mem [2**VRAM_AW];

	assign slot   = (enable_state == 2'd3);	// Only access slot
	assign accept = slot && !busy && vram_req;

	// Write completes in the accept cycle, read one cycle later
	assign vram_done = (accept && vram_cmd.we) || rd_done;

	// --------------------
	// Slot counter, clear pass
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			enable_state <= '0;
			clr_addr     <= '0;
			busy         <= 1'b1;
			rd_done      <= 1'b0;
		end else begin
			enable_state <= enable_state + 1'b1;
			rd_done      <= accept && !vram_cmd.we;
			if (slot && busy) begin
				clr_addr <= clr_addr + 1'b1;
				if (&clr_addr)
					busy <= 1'b0;		// Last address cleared
			end
		end
	end

	// --------------------
	// Array
	// --------------------
	always_ff @(posedge clk) begin
		if (slot && busy)
			mem[clr_addr] <= '0;
		else if (accept && vram_cmd.we)
			mem[vram_cmd.addr] <= vram_cmd.wdata;
		if (accept && !vram_cmd.we)
			vram_rdata <= mem[vram_cmd.addr];
	end

endmodule

`default_nettype wire

//--- hw/debugger/key_debugger.sv
// Keys are active low; a press during a running write sequence is ignored
`default_nettype none

module key_debugger
	import cart_pkg::*;
(
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic [1:0] keys,		// 0 = pressed
	input  logic       ack,
	output logic       req,
	output vdp_req_t   cmd
);

	typedef enum logic [1:0] {
		DBG_IDLE,
		DBG_VAL,	// Value byte on port 1
		DBG_GAP,	// req low for one cycle
		DBG_REG		// 87h, write register 7
	} dbg_state_e;

	dbg_state_e        state;
	logic [1:0]        key_meta;
	logic [1:0]        key_sync;
	logic [1:0]        key_stable;	// Debounced level
	logic [DEB_CW-1:0] deb_cnt [2];
	logic [1:0]        press;		// Accepted 1 -> 0 edge, one cycle
	logic [7:0]        shadow;		// Copy of the value sent to register 7

	// --------------------
	// Debounce
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			key_meta   <= 2'b11;
			key_sync   <= 2'b11;
			key_stable <= 2'b11;
			press      <= '0;
			deb_cnt[0] <= '0;
			deb_cnt[1] <= '0;
		end else begin
			key_meta <= keys;
			key_sync <= key_meta;
			for (int k = 0; k < 2; k++) begin
				press[k] <= 1'b0;
				if (key_sync[k] == key_stable[k]) begin
					deb_cnt[k] <= '0;		// Bounce restarts the count
				end else if (deb_cnt[k] == DEB_CW'(DEBOUNCE_CYCLES - 1)) begin
					key_stable[k] <= key_sync[k];
					press[k]      <= !key_sync[k];
					deb_cnt[k]    <= '0;
				end else begin
					deb_cnt[k] <= deb_cnt[k] + 1'b1;
				end
			end
		end
	end

	// --------------------
	// Write sequence
	// --------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state  <= DBG_IDLE;
			shadow <= '0;
		end else begin
			case (state)
				DBG_IDLE: begin
					if (press[0]) begin
						shadow <= shadow + 1'b1;	// Shadow is also the value byte
						state  <= DBG_VAL;
					end else if (press[1]) begin
						shadow <= '0;
						state  <= DBG_VAL;
					end
				end
				DBG_VAL: if (ack) state <= DBG_GAP;
				DBG_GAP: state <= DBG_REG;
				DBG_REG: if (ack) state <= DBG_IDLE;
				default: state <= DBG_IDLE;
			endcase
		end
	end

	assign req = (state == DBG_VAL) || (state == DBG_REG);
	assign cmd = '{wr: 1'b1, port: PORT_CTRL,
		wdata: (state == DBG_REG) ? DBG_REG7_CMD : shadow};

endmodule

`default_nettype wire

//--- hw/cart_top.sv
// Clock and synchronous reset come from outside; no video output, SDRAM or cartridge bus pins
`default_nettype none

module cart_top
	import cart_pkg::*;
(
	input  logic       clk,
	input  logic       w_n_reset,
	input  logic [1:0] keys,
	input  logic       host_req,
	input  vdp_req_t   host_cmd,
	output logic       host_ack,
	output logic [7:0] host_rdata,
	output logic [1:0] led,
	output logic       vram_busy
);

	logic       dbg_req;
	vdp_req_t   dbg_cmd;
	logic       dbg_ack;
	logic       vram_req;
	vram_req_t  vram_cmd;
	logic       vram_done;
	logic [7:0] vram_rdata;

	// --------------------
	// Blocks
	// --------------------
	vdp_port u_vdp_port (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.host_req   (host_req),
		.host_cmd   (host_cmd),
		.host_ack   (host_ack),
		.dbg_req    (dbg_req),
		.dbg_cmd    (dbg_cmd),
		.dbg_ack    (dbg_ack),
		.rdata      (host_rdata),
		.vram_req   (vram_req),
		.vram_cmd   (vram_cmd),
		.vram_done  (vram_done),
		.vram_rdata (vram_rdata),
		.led        (led)
	);

	vram_ctrl u_vram_ctrl (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.vram_req   (vram_req),
		.vram_cmd   (vram_cmd),
		.vram_done  (vram_done),
		.vram_rdata (vram_rdata),
		.busy       (vram_busy)		// Clear pass still running
	);

	key_debugger u_key_debugger (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.keys       (keys),
		.ack        (dbg_ack),
		.req        (dbg_req),
		.cmd        (dbg_cmd)
	);

endmodule

`default_nettype wire

//--- sim/tb_cart_top.sv
// Waits out the full VRAM clear pass first; key press timing assumes a two-stage key synchronizer
`default_nettype none

module tb_cart_top
	import cart_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ACK_TIMEOUT  = 100;
	localparam int BUSY_TIMEOUT = 80000;
	localparam int LED_TIMEOUT  = 1000;

	logic       clk;
	logic       w_n_reset;
	logic [1:0] keys;
	logic       host_req;
	vdp_req_t   host_cmd;
	logic       host_ack;
	logic [7:0] host_rdata;
	logic [1:0] led;
	logic       vram_busy;

	logic [31:0] lfsr;	// Random data state
	int          errors;
	int          timeouts;

	cart_top dut0 (
		.clk        (clk),
		.w_n_reset  (w_n_reset),
		.keys       (keys),
		.host_req   (host_req),
		.host_cmd   (host_cmd),
		.host_ack   (host_ack),
		.host_rdata (host_rdata),
		.led        (led),
		.vram_busy  (vram_busy)
	);

	always #5 clk = ~clk;	// 100 MHz

	// --------------------
	// Helpers
	// --------------------
	// Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};	// One step per bit
		end
	endtask

	task automatic check(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// One host access, req held until ack
	task automatic bus_access(input logic wr, input vdp_port_e port, input logic [7:0] wdata,
		output logic [7:0] rd);
		int n;
		bit got;
		rd  = 8'h00;
		got = 1'b0;
		n   = 0;
		@(posedge clk);
		host_req <= 1'b1;
		host_cmd <= '{wr: wr, port: port, wdata: wdata};
		while (!got && n < ACK_TIMEOUT) begin
			@(negedge clk);	// Outputs settled here
			if (host_ack) begin
				got = 1'b1;
				rd  = host_rdata;
			end
			n++;
		end
		if (!got) begin
			timeouts++;
			$display("Timeout: no ack on port %s after %0d cycles, port FSM in %s",
				port.name(), ACK_TIMEOUT, dut0.u_vdp_port.state.name());
		end
		@(posedge clk);
		host_req <= 1'b0;	// Low for at least one cycle
	endtask

	task automatic bus_write(input vdp_port_e port, input logic [7:0] wdata);
		logic [7:0] unused;
		bus_access(1'b1, port, wdata, unused);
	endtask

	task automatic bus_read(input vdp_port_e port, output logic [7:0] rd);
		bus_access(1'b0, port, 8'h00, rd);
	endtask

	task automatic set_addr(input logic [VRAM_AW-1:0] addr);
		bus_write(PORT_CTRL, addr[7:0]);
		bus_write(PORT_CTRL, {2'b00, addr[13:8]});	// Bit 7 clear, address setup
	endtask

	task automatic reg_write(input logic [2:0] r, input logic [7:0] v);
		bus_write(PORT_CTRL, v);
		bus_write(PORT_CTRL, {5'b10000, r});
	endtask

	task automatic wait_not_busy();
		int n;
		n = 0;
		while (vram_busy && n < BUSY_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (vram_busy) begin
			timeouts++;
			$display("Timeout: VRAM clear pass still busy after %0d cycles", BUSY_TIMEOUT);
		end
	endtask

	task automatic wait_led(input logic [1:0] exp);
		int n;
		n = 0;
		while (led !== exp && n < LED_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (led !== exp) begin
			timeouts++;
			$display("Timeout: LEDs did not reach %0d within %0d cycles", exp, LED_TIMEOUT);
		end
		check({6'd0, led}, {6'd0, exp}, "led value");
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic clear_pass();
		logic [7:0] rd;
		check({7'd0, vram_busy}, 8'h01, "busy after reset");
		wait_not_busy();
		set_addr(14'h0000);
		bus_read(PORT_DATA, rd);
		check(rd, 8'h00, "cleared VRAM at 0000");
		set_addr(14'h1234);
		bus_read(PORT_DATA, rd);
		check(rd, 8'h00, "cleared VRAM at 1234");
		set_addr(14'h3FFF);
		bus_read(PORT_DATA, rd);
		check(rd, 8'h00, "cleared VRAM at 3FFF");
	endtask

	task automatic burst_and_wrap();
		logic [31:0] v;
		logic [7:0]  data [8];
		logic [7:0]  rd;
		logic [VRAM_AW-1:0] base;
		rand_bits(VRAM_AW, v);
		base = v[VRAM_AW-1:0];
		set_addr(base);
		for (int i = 0; i < 8; i++) begin
			rand_bits(8, v);
			data[i] = v[7:0];
			bus_write(PORT_DATA, data[i]);	// Pointer steps by one
		end
		set_addr(base);
		for (int i = 0; i < 8; i++) begin
			bus_read(PORT_DATA, rd);
			check(rd, data[i], "burst readback");
		end
		// Last address, then the pointer wraps to 0
		set_addr(14'h3FFF);
		bus_write(PORT_DATA, data[0] ^ 8'h5A);
		bus_write(PORT_DATA, data[1] ^ 8'hA5);
		set_addr(14'h0000);
		bus_read(PORT_DATA, rd);
		check(rd, data[1] ^ 8'hA5, "wrapped write at 0000");
		set_addr(14'h3FFF);
		bus_read(PORT_DATA, rd);
		check(rd, data[0] ^ 8'h5A, "write at 3FFF");
	endtask

	task automatic register_writes();
		logic [31:0] v;
		rand_bits(4, v);
		reg_write(3'd7, {v[3:0], 4'h2});
		wait_led(2'd2);
		rand_bits(8, v);
		reg_write(3'd3, {v[7:2], 2'b01});	// Not the LED register, low bits differ from R#7
		repeat (4) @(negedge clk);
		check({6'd0, led}, 8'h02, "led after R#3 write");
	endtask

	task automatic latch_handling();
		logic [7:0] rd;
		bus_write(PORT_CTRL, 8'h01);	// First byte only
		bus_read(PORT_CTRL, rd);
		check(rd, 8'h80, "status with latch set");
		bus_read(PORT_CTRL, rd);
		check(rd, 8'h00, "status after latch clear");
		reg_write(3'd7, 8'h03);	// Must pair up fresh
		wait_led(2'd3);
	endtask

	task automatic unused_ports();
		logic [7:0] rd;
		set_addr(14'h0100);
		bus_write(PORT_DATA, 8'h3C);
		bus_read(PORT_PAL, rd);
		check(rd, 8'hFF, "port 2 read");
		bus_read(PORT_IND, rd);
		check(rd, 8'hFF, "port 3 read");
		bus_write(PORT_PAL, 8'hC3);	// Ignored
		set_addr(14'h0100);
		bus_read(PORT_DATA, rd);
		check(rd, 8'h3C, "VRAM after port 2 write");
		check({6'd0, led}, 8'h03, "led after port 2 write");
	endtask

	// Hold a key low; optionally collide a host status read with the first debugger request
	task automatic press_key(input int k, input bit with_read, input logic [1:0] exp);
		logic [7:0] rd;
		@(posedge clk);
		keys[k] <= 1'b0;
		if (with_read) begin
			repeat (DEBOUNCE_CYCLES + 2) @(posedge clk);	// Sync stages plus debounce
			bus_read(PORT_CTRL, rd);
			check(rd, 8'h00, "host status during key press");
			repeat (2 * DEBOUNCE_CYCLES - 6) @(posedge clk);
		end else begin
			repeat (3 * DEBOUNCE_CYCLES) @(posedge clk);
		end
		keys[k] <= 1'b1;
		wait_led(exp);
		repeat (3 * DEBOUNCE_CYCLES) @(posedge clk);	// Release settles
	endtask

	task automatic key_presses();
		press_key(0, 1'b1, 2'd1);
		press_key(0, 1'b0, 2'd2);
		press_key(1, 1'b0, 2'd0);
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		clk       = 1'b0;
		w_n_reset = 1'b0;
		keys      = 2'b11;	// Released
		host_req  = 1'b0;
		host_cmd  = '0;
		lfsr      = 32'h68bc44b9;
		errors    = 0;
		timeouts  = 0;
		repeat (3) @(posedge clk);
		w_n_reset <= 1'b1;
		@(negedge clk);
		clear_pass();
		burst_and_wrap();
		register_writes();
		latch_handling();
		unused_ports();
		key_presses();
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
common/cart_pkg.sv
hw/vdp/vdp_port.sv
hw/vdp/vram_ctrl.sv
hw/debugger/key_debugger.sv
hw/cart_top.sv
sim/tb_cart_top.sv

//--- Bender.yml
package:
  name: cart_top

sources:
  - common/cart_pkg.sv
  - hw/vdp/vdp_port.sv
  - hw/vdp/vram_ctrl.sv
  - hw/debugger/key_debugger.sv
  - hw/cart_top.sv
  - target: simulation
    files:
      - sim/tb_cart_top.sv
